// ==== common/tcdm_cfg.svh ====
/*
 * TCDM cluster memory configuration
 * initiator and bank counts, data/address widths and bank depth
 */
`ifndef TCDM_CFG_SVH
`define TCDM_CFG_SVH

// number of initiator ports
`define TCDM_NI     4

// number of banks, power of two (word interleaved)
`define TCDM_NB     4

// data word width in bits
`define TCDM_DW     32

// byte address width
`define TCDM_AW     10

// words per bank
`define TCDM_DEPTH  64

`endif

// ==== common/tcdm_pkg.sv ====
/*
 * TCDM package
 * derived widths, word types, request opcode and arbiter pointer state
 */
`include "tcdm_cfg.svh"

package tcdm_pkg;

  localparam int unsigned TCDM_NI    = `TCDM_NI;
  localparam int unsigned TCDM_NB    = `TCDM_NB;
  localparam int unsigned TCDM_DW    = `TCDM_DW;
  localparam int unsigned TCDM_AW    = `TCDM_AW;
  localparam int unsigned TCDM_DEPTH = `TCDM_DEPTH;
  localparam int unsigned TCDM_BW    = TCDM_DW / 8;          // one enable per byte
  localparam int unsigned TCDM_IW    = $clog2(TCDM_NI);      // initiator id width
  localparam int unsigned TCDM_OW    = $clog2(TCDM_BW);      // byte offset bits
  localparam int unsigned TCDM_SW    = $clog2(TCDM_NB);      // bank select bits
  localparam int unsigned TCDM_RW    = $clog2(TCDM_DEPTH);   // row bits inside a bank

  typedef logic [TCDM_IW-1:0] tcdm_id_t;
  typedef logic [TCDM_DW-1:0] tcdm_data_t;
  typedef logic [TCDM_AW-1:0] tcdm_addr_t;
  typedef logic [TCDM_BW-1:0] tcdm_be_t;

  // read is wen high, as on the TCDM bus
  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } tcdm_op_e;

  // round-robin pointer, one state per initiator
  typedef enum logic [TCDM_IW-1:0] {
    ARB_P0 = 2'd0,
    ARB_P1 = 2'd1,
    ARB_P2 = 2'd2,
    ARB_P3 = 2'd3
  } arb_state_e;

endpackage

// ==== hw/tcdm_req_xbar.sv ====
/*
 * TCDM request crossbar
 * word-interleaved bank decode, one round-robin arbiter per bank,
 * grant return to the initiators and id tagging of the winning request
 */
`timescale 1ns/1ns
`include "tcdm_cfg.svh"

module tcdm_req_xbar (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           clear_i,
  // initiator side
  input  logic                  [`TCDM_NI-1:0]           in_req,
  input  tcdm_pkg::tcdm_op_e    [`TCDM_NI-1:0]           in_wen,
  input  tcdm_pkg::tcdm_addr_t  [`TCDM_NI-1:0]           in_add,
  input  tcdm_pkg::tcdm_data_t  [`TCDM_NI-1:0]           in_data,
  input  tcdm_pkg::tcdm_be_t    [`TCDM_NI-1:0]           in_be,
  output logic                  [`TCDM_NI-1:0]           in_gnt,
  // bank side
  output logic                  [`TCDM_NB-1:0]           bank_req,
  output tcdm_pkg::tcdm_op_e    [`TCDM_NB-1:0]           bank_wen,
  output logic [`TCDM_NB-1:0][tcdm_pkg::TCDM_RW-1:0]     bank_add,
  output tcdm_pkg::tcdm_data_t  [`TCDM_NB-1:0]           bank_data,
  output tcdm_pkg::tcdm_be_t    [`TCDM_NB-1:0]           bank_be,
  output tcdm_pkg::tcdm_id_t    [`TCDM_NB-1:0]           bank_id,
  input  logic                  [`TCDM_NB-1:0]           bank_gnt
);
  import tcdm_pkg::*;

  logic       [TCDM_NI-1:0][TCDM_SW-1:0] sel_bank;  // target bank per initiator
  logic       [TCDM_NI-1:0][TCDM_RW-1:0] sel_row;   // row inside that bank
  logic       [TCDM_NB-1:0]              win_vld;   // bank has a contender
  tcdm_id_t                              win_id [TCDM_NB];
  arb_state_e                            ptr_q  [TCDM_NB];

  // interleaving: low word bits pick the bank, upper bits the row
  always_comb begin
    for (int i = 0; i < TCDM_NI; i++) begin
      sel_bank[i] = in_add[i][TCDM_OW +: TCDM_SW];
      sel_row[i]  = in_add[i][TCDM_OW+TCDM_SW +: TCDM_RW];
    end
  end

  // round-robin pick starting at the pointer
  always_comb begin
    int unsigned idx;
    for (int b = 0; b < TCDM_NB; b++) begin
      win_vld[b] = 1'b0;
      win_id[b]  = '0;
      // walk backwards so the contender closest to the pointer is the last hit
      for (int k = TCDM_NI-1; k >= 0; k--) begin
        idx = (int'(ptr_q[b]) + k) % TCDM_NI;
        if (in_req[idx] && (sel_bank[idx] == TCDM_SW'(b))) begin
          win_vld[b] = 1'b1;
          win_id[b]  = tcdm_id_t'(idx);
        end
      end
    end
  end

  // forward the winner, its index becomes the id
  always_comb begin
    for (int b = 0; b < TCDM_NB; b++) begin
      bank_req[b]  = win_vld[b];
      bank_wen[b]  = in_wen[win_id[b]];
      bank_add[b]  = sel_row[win_id[b]];
      bank_data[b] = in_data[win_id[b]];
      bank_be[b]   = in_be[win_id[b]];
      bank_id[b]   = win_id[b];
    end
  end

  // grant only the winner, and only if its bank grants
  always_comb begin
    for (int i = 0; i < TCDM_NI; i++) begin
      in_gnt[i] = in_req[i]
                & win_vld[sel_bank[i]]
                & (win_id[sel_bank[i]] == tcdm_id_t'(i))
                & bank_gnt[sel_bank[i]];
    end
  end

  // pointer moves one past the granted initiator
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int b = 0; b < TCDM_NB; b++) begin
        ptr_q[b] <= ARB_P0;
      end
    end else if (clear_i) begin
      for (int b = 0; b < TCDM_NB; b++) begin
        ptr_q[b] <= ARB_P0;                             // restart at initiator 0
      end
    end else begin
      for (int b = 0; b < TCDM_NB; b++) begin
        if (bank_req[b] && bank_gnt[b]) begin
          ptr_q[b] <= arb_state_e'(tcdm_id_t'((win_id[b] + 1) % TCDM_NI));
        end
      end
    end
  end

endmodule

// ==== hw/tcdm_r_id_filter.sv ====
/*
 * TCDM r_id filter
 * passes a bank request through with its id zeroed and returns the
 * registered id as r_id with the 1-cycle bank response
 */
`timescale 1ns/1ns

module tcdm_r_id_filter (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  // target side, towards the crossbar
  input  logic                            tgt_req,
  input  tcdm_pkg::tcdm_op_e              tgt_wen,
  input  logic [tcdm_pkg::TCDM_RW-1:0]    tgt_add,
  input  tcdm_pkg::tcdm_data_t            tgt_data,
  input  tcdm_pkg::tcdm_be_t              tgt_be,
  input  tcdm_pkg::tcdm_id_t              tgt_id,
  output logic                            tgt_gnt,
  output logic                            tgt_r_valid,
  output tcdm_pkg::tcdm_data_t            tgt_r_data,
  output tcdm_pkg::tcdm_id_t              tgt_r_id,
  // initiator side, towards the bank
  output logic                            ini_req,
  output tcdm_pkg::tcdm_op_e              ini_wen,
  output logic [tcdm_pkg::TCDM_RW-1:0]    ini_add,
  output tcdm_pkg::tcdm_data_t            ini_data,
  output tcdm_pkg::tcdm_be_t              ini_be,
  output tcdm_pkg::tcdm_id_t              ini_id,
  input  logic                            ini_gnt,
  input  logic                            ini_r_valid,
  input  tcdm_pkg::tcdm_data_t            ini_r_data
);
  import tcdm_pkg::*;

  tcdm_id_t id_q;  // id of the request now inside the bank

  assign ini_req     = tgt_req;
  assign ini_wen     = tgt_wen;
  assign ini_add     = tgt_add;
  assign ini_data    = tgt_data;
  assign ini_be      = tgt_be;
  assign ini_id      = '0;                  // bank needs no id
  assign tgt_gnt     = ini_gnt;
  assign tgt_r_valid = ini_r_valid;
  assign tgt_r_data  = ini_r_data;
  assign tgt_r_id    = id_q;                // lines up with r_valid one cycle later

  // only correct at the 1-cycle latency boundary
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_q <= '0;
    end else if (clear_i) begin
      id_q <= '0;
    end else if (tgt_req) begin
      id_q <= tgt_id;
    end
  end

endmodule

// ==== hw/tcdm_sram_bank.sv ====
/*
 * TCDM SRAM bank
 * single-port word memory with byte-enable writes, always grants
 * and answers every accepted request one cycle later
 */
`timescale 1ns/1ns

module tcdm_sram_bank (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            req,
  input  tcdm_pkg::tcdm_op_e              wen,
  input  logic [tcdm_pkg::TCDM_RW-1:0]    add,
  input  tcdm_pkg::tcdm_data_t            data,
  input  tcdm_pkg::tcdm_be_t              be,
  output logic                            gnt,
  output logic                            r_valid,
  output tcdm_pkg::tcdm_data_t            r_data
);
  import tcdm_pkg::*;

  tcdm_data_t mem_q [TCDM_DEPTH];  // storage array
  tcdm_data_t r_data_q;            // read word, held for the response cycle
  logic       r_valid_q;

  assign gnt     = req;            // no stall, every request accepted
  assign r_valid = r_valid_q;
  assign r_data  = r_data_q;

  // write updates only enabled bytes
  always_ff @(posedge clk_i) begin
    if (req && (wen == OP_WRITE)) begin
      for (int k = 0; k < TCDM_BW; k++) begin
        if (be[k]) begin
          mem_q[add][8*k +: 8] <= data[8*k +: 8];
        end
      end
    end
  end

  // read port, old word on a write (don't care there)
  always_ff @(posedge clk_i) begin
    if (req) begin
      r_data_q <= mem_q[add];
    end
  end

  // response valid exactly the cycle after acceptance
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= req;
    end
  end

endmodule

// ==== hw/tcdm_resp_router.sv ====
/*
 * TCDM response router
 * steers each bank response back to the initiator named by its r_id
 */
`timescale 1ns/1ns
`include "tcdm_cfg.svh"

module tcdm_resp_router (
  input  logic                  [`TCDM_NB-1:0] bank_r_valid,
  input  tcdm_pkg::tcdm_data_t  [`TCDM_NB-1:0] bank_r_data,
  input  tcdm_pkg::tcdm_id_t    [`TCDM_NB-1:0] bank_r_id,
  output logic                  [`TCDM_NI-1:0] out_r_valid,
  output tcdm_pkg::tcdm_data_t  [`TCDM_NI-1:0] out_r_data
);
  import tcdm_pkg::*;

  // one accepted request per initiator per cycle, so at most one match
  always_comb begin
    for (int i = 0; i < TCDM_NI; i++) begin
      out_r_valid[i] = 1'b0;
      out_r_data[i]  = '0;
      for (int b = 0; b < TCDM_NB; b++) begin
        if (bank_r_valid[b] && (bank_r_id[b] == tcdm_id_t'(i))) begin
          out_r_valid[i] = 1'b1;
          out_r_data[i]  = bank_r_data[b];        // data of the matching bank
        end
      end
    end
  end

endmodule

// ==== hw/tcdm_cluster_mem.sv ====
/*
 * TCDM cluster memory slice
 * request crossbar, one r_id filter and SRAM bank per bank,
 * and the response router back to the initiators
 */
`timescale 1ns/1ns
`include "tcdm_cfg.svh"

module tcdm_cluster_mem (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 clear_i,
  input  logic                  [`TCDM_NI-1:0] req,
  input  tcdm_pkg::tcdm_op_e    [`TCDM_NI-1:0] wen,
  input  tcdm_pkg::tcdm_addr_t  [`TCDM_NI-1:0] add,
  input  tcdm_pkg::tcdm_data_t  [`TCDM_NI-1:0] data,
  input  tcdm_pkg::tcdm_be_t    [`TCDM_NI-1:0] be,
  output logic                  [`TCDM_NI-1:0] gnt,
  output logic                  [`TCDM_NI-1:0] r_valid,
  output tcdm_pkg::tcdm_data_t  [`TCDM_NI-1:0] r_data
);
  import tcdm_pkg::*;

  // crossbar to filters
  logic       [TCDM_NB-1:0]              xb_req;
  tcdm_op_e   [TCDM_NB-1:0]              xb_wen;
  logic       [TCDM_NB-1:0][TCDM_RW-1:0] xb_add;
  tcdm_data_t [TCDM_NB-1:0]              xb_data;
  tcdm_be_t   [TCDM_NB-1:0]              xb_be;
  tcdm_id_t   [TCDM_NB-1:0]              xb_id;
  logic       [TCDM_NB-1:0]              xb_gnt;
  // filters to banks
  logic       [TCDM_NB-1:0]              bk_req;
  tcdm_op_e   [TCDM_NB-1:0]              bk_wen;
  logic       [TCDM_NB-1:0][TCDM_RW-1:0] bk_add;
  tcdm_data_t [TCDM_NB-1:0]              bk_data;
  tcdm_be_t   [TCDM_NB-1:0]              bk_be;
  logic       [TCDM_NB-1:0]              bk_gnt;
  logic       [TCDM_NB-1:0]              bk_r_valid;
  tcdm_data_t [TCDM_NB-1:0]              bk_r_data;
  // filters to router
  logic       [TCDM_NB-1:0]              rsp_valid;
  tcdm_data_t [TCDM_NB-1:0]              rsp_data;
  tcdm_id_t   [TCDM_NB-1:0]              rsp_id;

  tcdm_req_xbar i_req_xbar (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .clear_i   (clear_i),
    .in_req    (req),
    .in_wen    (wen),
    .in_add    (add),
    .in_data   (data),
    .in_be     (be),
    .in_gnt    (gnt),
    .bank_req  (xb_req),
    .bank_wen  (xb_wen),
    .bank_add  (xb_add),
    .bank_data (xb_data),
    .bank_be   (xb_be),
    .bank_id   (xb_id),
    .bank_gnt  (xb_gnt)
  );

  // one filter + bank pair per bank, filter at the 1-cycle boundary
  for (genvar b = 0; b < TCDM_NB; b++) begin : g_bank
    tcdm_r_id_filter i_r_id_filter (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .clear_i     (clear_i),
      .tgt_req     (xb_req[b]),
      .tgt_wen     (xb_wen[b]),
      .tgt_add     (xb_add[b]),
      .tgt_data    (xb_data[b]),
      .tgt_be      (xb_be[b]),
      .tgt_id      (xb_id[b]),
      .tgt_gnt     (xb_gnt[b]),
      .tgt_r_valid (rsp_valid[b]),
      .tgt_r_data  (rsp_data[b]),
      .tgt_r_id    (rsp_id[b]),
      .ini_req     (bk_req[b]),
      .ini_wen     (bk_wen[b]),
      .ini_add     (bk_add[b]),
      .ini_data    (bk_data[b]),
      .ini_be      (bk_be[b]),
      .ini_id      (),                        // bank has no id input
      .ini_gnt     (bk_gnt[b]),
      .ini_r_valid (bk_r_valid[b]),
      .ini_r_data  (bk_r_data[b])
    );

    tcdm_sram_bank i_sram_bank (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req     (bk_req[b]),
      .wen     (bk_wen[b]),
      .add     (bk_add[b]),
      .data    (bk_data[b]),
      .be      (bk_be[b]),
      .gnt     (bk_gnt[b]),
      .r_valid (bk_r_valid[b]),
      .r_data  (bk_r_data[b])
    );
  end

  tcdm_resp_router i_resp_router (
    .bank_r_valid (rsp_valid),
    .bank_r_data  (rsp_data),
    .bank_r_id    (rsp_id),
    .out_r_valid  (r_valid),
    .out_r_data   (r_data)
  );

endmodule

// ==== sim/tcdm_cluster_mem_chk.sv ====
/*
 * TCDM cluster memory assertions
 * bound to the top level, watches the crossbar-to-filter wires of every
 * bank path and the grant/response rules of every initiator
 */
`timescale 1ns/1ns
`include "tcdm_cfg.svh"

module tcdm_cluster_mem_chk (
  input logic                clk_i,
  input logic                rst_ni,
  input logic [`TCDM_NI-1:0] req,
  input logic [`TCDM_NI-1:0] gnt,
  input logic [`TCDM_NI-1:0] r_valid,
  input logic [`TCDM_NB-1:0] flt_req,      // filter target-side request
  input logic [`TCDM_NB-1:0] flt_r_valid   // filter target-side response
);
  import tcdm_pkg::*;

  int unsigned fail_cnt = 0;  // failed assertions so far

  for (genvar b = 0; b < TCDM_NB; b++) begin : g_flt
    // bank request answered exactly one cycle later
    a_req_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
      flt_req[b] |=> flt_r_valid[b])
      else begin
        $error("filter %0d: request without response one cycle later", b);
        fail_cnt++;
      end
    a_idle_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !flt_req[b] |=> !flt_r_valid[b])
      else begin
        $error("filter %0d: response without a request", b);
        fail_cnt++;
      end
  end

  for (genvar i = 0; i < TCDM_NI; i++) begin : g_ini
    // no contender, so the bank is free and the grant comes at once
    a_lone_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ($onehot(req) && req[i]) |-> gnt[i])
      else begin
        $error("initiator %0d: lone request not granted", i);
        fail_cnt++;
      end
    // response only on the initiator accepted one cycle earlier
    a_rsp_owner: assert property (@(posedge clk_i) disable iff (!rst_ni)
      r_valid[i] |-> $past(req[i] & gnt[i]))
      else begin
        $error("initiator %0d: response without accepted request", i);
        fail_cnt++;
      end
  end

endmodule

bind tcdm_cluster_mem tcdm_cluster_mem_chk i_chk (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .req         (req),
  .gnt         (gnt),
  .r_valid     (r_valid),
  .flt_req     (xb_req),
  .flt_r_valid (rsp_valid)
);

// ==== sim/tb_tcdm_cluster_mem.sv ====
/*
 * testbench for the TCDM cluster memory
 * directed accesses from a pattern file, random contention and a clear
 * check, all against a reference memory and a round-robin grant model
 */
`timescale 1ns/1ns

module tb_tcdm_cluster_mem;
  import tcdm_pkg::*;

  localparam int unsigned NWORDS  = TCDM_NB * TCDM_DEPTH;
  localparam int unsigned TIMEOUT = 20;                    // cycles per wait loop

  logic                     clk_i;
  logic                     rst_ni;
  logic                     clear_i;
  logic       [TCDM_NI-1:0] req;
  tcdm_op_e   [TCDM_NI-1:0] wen;
  tcdm_addr_t [TCDM_NI-1:0] add;
  tcdm_data_t [TCDM_NI-1:0] data;
  tcdm_be_t   [TCDM_NI-1:0] be;
  logic       [TCDM_NI-1:0] gnt;
  logic       [TCDM_NI-1:0] r_valid;
  tcdm_data_t [TCDM_NI-1:0] r_data;

  logic        pend     [TCDM_NI];  // request held until granted
  tcdm_op_e    p_op     [TCDM_NI];
  tcdm_addr_t  p_add    [TCDM_NI];
  tcdm_data_t  p_data   [TCDM_NI];
  tcdm_be_t    p_be     [TCDM_NI];
  int unsigned wait_cyc [TCDM_NI];  // cycles spent waiting for gnt
  logic        f_vld    [TCDM_NI];  // expected read word comes from the file
  tcdm_data_t  f_exp    [TCDM_NI];
  logic        exp_rv   [TCDM_NI];  // response due next cycle
  logic        exp_chk  [TCDM_NI];  // ... and it carries read data
  tcdm_data_t  exp_rd   [TCDM_NI];
  tcdm_data_t  ref_mem  [NWORDS];   // reference memory, word indexed
  int unsigned ptr      [TCDM_NB];  // round-robin pointer model
  logic [31:0] lfsr = 32'h4b81;

  tcdm_cluster_mem i_tcdm_cluster_mem (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),
    .req     (req),
    .wen     (wen),
    .add     (add),
    .data    (data),
    .be      (be),
    .gnt     (gnt),
    .r_valid (r_valid),
    .r_data  (r_data)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic int unsigned word_of(tcdm_addr_t a);
    return a / TCDM_BW;
  endfunction

  function automatic int unsigned bank_of(tcdm_addr_t a);
    return word_of(a) % TCDM_NB;                            // word interleaving
  endfunction

  function automatic tcdm_data_t merge(tcdm_data_t old_w, tcdm_data_t new_w, tcdm_be_t en);
    tcdm_data_t m;
    m = old_w;
    for (int k = 0; k < TCDM_BW; k++) begin
      if (en[k]) m[8*k +: 8] = new_w[8*k +: 8];             // enabled bytes only
    end
    return m;
  endfunction

  function automatic tcdm_data_t fill_word(int unsigned w);
    logic [7:0] wb;
    wb = w[7:0];                                            // whole word index
    return {wb ^ 8'h5a, ~wb, wb, wb + 8'hc3};
  endfunction

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic stop_run(string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_valid(string name, logic got, logic exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch at %0t ns: %s got %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_data(string name, tcdm_data_t got, tcdm_data_t exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic post(int n, tcdm_op_e op, tcdm_addr_t a, tcdm_data_t d, tcdm_be_t en);
    pend[n]     = 1'b1;
    p_op[n]     = op;
    p_add[n]    = a;
    p_data[n]   = d;
    p_be[n]     = en;
    wait_cyc[n] = 0;
    f_vld[n]    = 1'b0;
  endtask

  task automatic drive_pins();
    for (int n = 0; n < TCDM_NI; n++) begin
      req[n]  = pend[n];
      wen[n]  = p_op[n];
      add[n]  = p_add[n];
      data[n] = p_data[n];
      be[n]   = p_be[n];
    end
  endtask

  // one clock: drive, check last responses and this cycle's grants, commit
  task automatic run_cycle();
    logic [TCDM_NI-1:0] exp_g;
    logic               found;
    int unsigned        i;
    int unsigned        w;
    drive_pins();
    @(negedge clk_i);                                       // outputs settled
    for (int n = 0; n < TCDM_NI; n++) begin
      check_valid($sformatf("r_valid[%0d]", n), r_valid[n], exp_rv[n]);
      if (exp_chk[n]) check_data($sformatf("r_data[%0d]", n), r_data[n], exp_rd[n]);
    end
    exp_g = '0;
    for (int b = 0; b < TCDM_NB; b++) begin
      found = 1'b0;
      for (int k = 0; k < TCDM_NI; k++) begin
        i = (ptr[b] + k) % TCDM_NI;                         // first requester from pointer
        if (!found && pend[i] && bank_of(p_add[i]) == b) begin
          exp_g[i] = 1'b1;
          found    = 1'b1;
        end
      end
    end
    for (int n = 0; n < TCDM_NI; n++) begin
      check_valid($sformatf("gnt[%0d]", n), gnt[n], exp_g[n]);
      exp_rv[n]  = exp_g[n];
      exp_chk[n] = exp_g[n] && (p_op[n] == OP_READ);
      if (exp_g[n]) begin
        w         = word_of(p_add[n]);
        exp_rd[n] = f_vld[n] ? f_exp[n] : ref_mem[w];
        if (p_op[n] == OP_WRITE) ref_mem[w] = merge(ref_mem[w], p_data[n], p_be[n]);
        ptr[bank_of(p_add[n])] = (n + 1) % TCDM_NI;         // one past the winner
        pend[n] = 1'b0;
      end else if (pend[n]) begin
        wait_cyc[n]++;
        if (wait_cyc[n] >= TCDM_NI) begin
          stop_run($sformatf("initiator %0d not granted within %0d cycles", n, TCDM_NI));
        end
      end
    end
    if (clear_i) begin
      for (int b = 0; b < TCDM_NB; b++) ptr[b] = 0;         // clear wins over a grant
    end
    @(posedge clk_i);
    #1;
  endtask

  function automatic logic busy();
    logic any;
    any = 1'b0;
    for (int n = 0; n < TCDM_NI; n++) any |= pend[n] | exp_rv[n];
    return any;
  endfunction

  task automatic drain(string what);
    int unsigned cnt;
    cnt = 0;
    while (busy()) begin
      run_cycle();
      cnt++;
      if (cnt > TIMEOUT) stop_run($sformatf("timeout while waiting for %s", what));
    end
  endtask

  initial begin
    int          fd;
    int          cnt;
    int          ini;
    int          op;
    int          nlines;
    string       line;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] b;
    logic [31:0] e;
    logic [31:0] v;
    rst_ni  = 1'b0;
    clear_i = 1'b0;
    for (int n = 0; n < TCDM_NI; n++) begin
      pend[n]    = 1'b0;
      p_op[n]    = OP_READ;
      p_add[n]   = '0;
      p_data[n]  = '0;
      p_be[n]    = '0;
      f_vld[n]   = 1'b0;
      exp_rv[n]  = 1'b0;
      exp_chk[n] = 1'b0;
    end
    for (int k = 0; k < TCDM_NB; k++) ptr[k] = 0;
    drive_pins();
    repeat (10) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    // directed accesses, one at a time
    fd = $fopen("sim/tcdm_patterns.txt", "r");
    if (fd == 0) stop_run("cannot open the pattern file sim/tcdm_patterns.txt");
    nlines = 0;
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      cnt = $sscanf(line, "%d %d %h %h %h %h", ini, op, a, d, b, e);
      if (cnt != 6) stop_run($sformatf("unreadable pattern line: %s", line));
      post(ini, tcdm_op_e'(op), tcdm_addr_t'(a), d, tcdm_be_t'(b));
      f_vld[ini] = 1'b1;
      f_exp[ini] = e;
      drain("a directed access");
      nlines++;
    end
    $fclose(fd);
    if (nlines == 0) stop_run("the pattern file holds no accesses");

    // fill every word, each initiator on its own bank
    for (int k = 0; k < TCDM_DEPTH; k++) begin
      for (int n = 0; n < TCDM_NI; n++) begin
        post(n, OP_WRITE, tcdm_addr_t'((k * TCDM_NB + n % TCDM_NB) * TCDM_BW),
             fill_word(k * TCDM_NB + n % TCDM_NB), '1);
      end
      run_cycle();
    end
    drain("the fill");

    // random contention, new requests only on idle initiators
    for (int c = 0; c < 400; c++) begin
      for (int n = 0; n < TCDM_NI; n++) begin
        if (!pend[n]) begin
          draw_bits(1, v);
          if (v[0]) begin
            draw_bits(1, v);
            op = v[0];
            draw_bits($clog2(NWORDS), a);
            draw_bits(TCDM_DW, d);
            post(n, tcdm_op_e'(op), tcdm_addr_t'(a * TCDM_BW), d, '1);
          end
        end
      end
      run_cycle();
    end
    drain("the contention phase");

    // move bank 0 pointer off zero, clear, then full conflict on bank 0
    post(2, OP_READ, '0, '0, '1);
    drain("the pre-clear access");
    clear_i = 1'b1;
    run_cycle();
    clear_i = 1'b0;
    for (int n = 0; n < TCDM_NI; n++) begin
      post(n, OP_READ, tcdm_addr_t'(TCDM_NB * (n + 5) * TCDM_BW), '0, '1);
    end
    drain("the conflict after clear");

    if (i_tcdm_cluster_mem.i_chk.fail_cnt != 0) begin
      stop_run("one or more assertions failed during the run");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// ==== tcdm_cluster_mem.f ====
+incdir+common
common/tcdm_pkg.sv
hw/tcdm_req_xbar.sv
hw/tcdm_r_id_filter.sv
hw/tcdm_sram_bank.sv
hw/tcdm_resp_router.sv
hw/tcdm_cluster_mem.sv
sim/tcdm_cluster_mem_chk.sv
sim/tb_tcdm_cluster_mem.sv

// ==== Makefile ====
# Verilator build and run for the TCDM cluster memory testbench

VERILATOR ?= verilator
TOP       ?= tb_tcdm_cluster_mem
FILELIST  ?= tcdm_cluster_mem.f
PATTERNS  ?= sim/tcdm_patterns.txt
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard common/*.svh) $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN) $(PATTERNS)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tcdm_patterns.txt ====
# initiator opcode(0 write, 1 read) byte_address data byte_enables expected_read_data
# expected_read_data is only compared on reads, hex fields without prefix
0 0 000 11111111 f 00000000
1 1 000 00000000 f 11111111
1 0 004 22222222 f 00000000
2 1 004 00000000 f 22222222
2 0 008 33333333 f 00000000
3 1 008 00000000 f 33333333
3 0 00c 44444444 f 00000000
0 1 00c 00000000 f 44444444
0 0 3f0 deadbeef f 00000000
1 1 3f0 00000000 f deadbeef
2 0 3fc cafef00d f 00000000
3 1 3fc 00000000 f cafef00d
0 0 100 a5a5a5a5 f 00000000
0 0 100 12345678 1 00000000
1 1 100 00000000 f a5a5a578
2 0 100 9abcdef0 6 00000000
3 1 100 00000000 f a5bcde78
1 0 214 00000000 f 00000000
1 0 214 ffffffff 8 00000000
2 1 214 00000000 f ff000000
3 0 214 55aa55aa 3 00000000
0 1 214 00000000 f ff0055aa
2 0 128 01020304 f 00000000
2 0 128 a0b0c0d0 a 00000000
1 1 128 00000000 f a002c004
3 0 36c 76543210 f 00000000
3 0 36c 00ff00ff 5 00000000
0 1 36c 00000000 f 76ff32ff
1 1 000 00000000 f 11111111
3 1 004 00000000 f 22222222
